// File: hw/cfg_pkg.sv
package cfg_pkg;

  // field widths of one configuration frame
  localparam int ID_BITS      = 8;
  localparam int PAYLOAD_BITS = 16;
  localparam int FRAME_BITS   = ID_BITS + PAYLOAD_BITS;

  // the bit counter must hold the longest field length
  localparam int CNT_BITS = $clog2(PAYLOAD_BITS + 1);

  // serial configuration stream, one bit per valid cycle
  typedef struct packed {
    logic valid;  // a bit is present this cycle
    logic value;  // the bit itself
  } config_s;

  // frame as collected by the shift register, address on top
  typedef struct packed {
    logic [ID_BITS-1:0]      id;
    logic [PAYLOAD_BITS-1:0] payload;
  } cfg_frame_s;

  // parser phases
  typedef enum logic [1:0] {
    ST_IDLE,     // waiting for a start bit of 1
    ST_ID,       // collecting the address, MSB first
    ST_PAYLOAD,  // collecting the payload, MSB first
    ST_STOP      // expecting a stop bit of 0
  } cfg_state_e;

endpackage

// File: hw/cfg_bit_counter.sv
module cfg_bit_counter #(
  parameter int W = 5
) (
  input  logic         clk,
  input  logic         rst_n_i,
  input  logic         load_i,
  input  logic [W-1:0] len_i,
  input  logic         dec_i,
  output logic         last_o
);

  logic [W-1:0] count_q;

  // load has priority, so the FSM can reload on the last bit of a field
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= len_i;
    end else if (dec_i && (count_q != '0)) begin
      count_q <= count_q - W'(1);  // one sampled bit consumed
    end
  end

  // the bit being sampled now closes the field
  assign last_o = (count_q == W'(1));

endmodule

// File: hw/cfg_shift_reg.sv
module cfg_shift_reg (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               shift_i,
  input  logic               bit_i,
  output cfg_pkg::cfg_frame_s frame_o
);

  import cfg_pkg::*;

  logic [FRAME_BITS-1:0] shift_q;

  // address bits enter first and end up in the upper part of the register,
  // the payload fills the lower part behind them
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      shift_q <= '0;
    end else if (shift_i) begin
      shift_q <= {shift_q[FRAME_BITS-2:0], bit_i};  // msb first
    end
  end

  // held through the stop bit and the done strobe since nothing shifts then
  assign frame_o = cfg_frame_s'(shift_q);

endmodule

// File: hw/cfg_frame_fsm.sv
module cfg_frame_fsm (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  cfg_pkg::config_s             cfg_i,
  input  logic                         cnt_last_i,
  output logic                         cnt_load_o,
  output logic [cfg_pkg::CNT_BITS-1:0] cnt_len_o,
  output logic                         cnt_dec_o,
  output logic                         shift_en_o,
  output logic                         frame_done_o,
  output logic                         frame_err_o
);

  import cfg_pkg::*;

  cfg_state_e state_q, state_d;
  logic       done_q;
  logic       err_q;
  logic       in_field;  // sampled bit is part of address or payload

  assign in_field = cfg_i.valid && ((state_q == ST_ID) || (state_q == ST_PAYLOAD));

  assign shift_en_o = in_field;
  assign cnt_dec_o  = in_field;

  // a start bit arms the address length, the last address bit arms the payload
  always_comb begin
    cnt_load_o = 1'b0;
    cnt_len_o  = CNT_BITS'(PAYLOAD_BITS);
    if (cfg_i.valid) begin
      if (state_q == ST_IDLE && cfg_i.value) begin
        cnt_load_o = 1'b1;
        cnt_len_o  = CNT_BITS'(ID_BITS);
      end else if (state_q == ST_ID && cnt_last_i) begin
        cnt_load_o = 1'b1;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    if (cfg_i.valid) begin  // gaps in valid hold every phase
      unique case (state_q)
        ST_IDLE:    if (cfg_i.value) state_d = ST_ID;
        ST_ID:      if (cnt_last_i) state_d = ST_PAYLOAD;
        ST_PAYLOAD: if (cnt_last_i) state_d = ST_STOP;
        ST_STOP:    state_d = ST_IDLE;  // good or bad stop, start over
        default:    state_d = ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // strobes last exactly one cycle after the stop bit edge
      done_q  <= (state_q == ST_STOP) && cfg_i.valid && !cfg_i.value;
      err_q   <= (state_q == ST_STOP) && cfg_i.valid && cfg_i.value;
    end
  end

  assign frame_done_o = done_q;
  assign frame_err_o  = err_q;

endmodule

// File: hw/cfg_node.sv
module cfg_node #(
  parameter int                     id_p        = 0,
  parameter int                     data_bits_p = 8,
  parameter logic [data_bits_p-1:0] reset_val_p = '0
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  cfg_pkg::cfg_frame_s    frame_i,
  input  logic                   frame_done_i,
  output logic [data_bits_p-1:0] data_o
);

  import cfg_pkg::*;

  localparam logic [ID_BITS-1:0] NODE_ID = ID_BITS'(id_p);

  logic                   hit;
  logic [data_bits_p-1:0] data_q;

  // address decode lives only in the node
  assign hit = frame_done_i && (frame_i.id == NODE_ID);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      data_q <= reset_val_p;
    end else if (hit) begin
      data_q <= frame_i.payload[data_bits_p-1:0];  // narrow nodes keep the low bits
    end
  end

  assign data_o = data_q;

endmodule

// File: hw/cfg_network.sv
module cfg_network #(
  parameter int                    id_a_p    = 3,
  parameter int                    bits_a_p  = 8,
  parameter logic [bits_a_p-1:0]   reset_a_p = 8'h5a,
  parameter int                    id_b_p    = 17,
  parameter int                    bits_b_p  = 16,
  parameter logic [bits_b_p-1:0]   reset_b_p = 16'h1234,
  parameter int                    id_c_p    = 200,
  parameter int                    bits_c_p  = 4,
  parameter logic [bits_c_p-1:0]   reset_c_p = 4'h9
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  cfg_pkg::config_s      cfg_i,
  output logic [bits_a_p-1:0]   data_a_o,
  output logic [bits_b_p-1:0]   data_b_o,
  output logic [bits_c_p-1:0]   data_c_o,
  output logic                  frame_done_o,
  output logic                  frame_err_o
);

  import cfg_pkg::*;

  logic                cnt_load;
  logic [CNT_BITS-1:0] cnt_len;
  logic                cnt_dec;
  logic                cnt_last;
  logic                shift_en;
  logic                frame_done;
  cfg_frame_s          frame;

  // shared parser
  cfg_frame_fsm u_fsm (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .cfg_i        (cfg_i),
    .cnt_last_i   (cnt_last),
    .cnt_load_o   (cnt_load),
    .cnt_len_o    (cnt_len),
    .cnt_dec_o    (cnt_dec),
    .shift_en_o   (shift_en),
    .frame_done_o (frame_done),
    .frame_err_o  (frame_err_o)
  );

  cfg_bit_counter #(
    .W (CNT_BITS)
  ) u_counter (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .load_i  (cnt_load),
    .len_i   (cnt_len),
    .dec_i   (cnt_dec),
    .last_o  (cnt_last)
  );

  cfg_shift_reg u_shift (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .shift_i (shift_en),
    .bit_i   (cfg_i.value),  // valid is already folded into shift_en
    .frame_o (frame)
  );

  // the three configurable registers
  cfg_node #(
    .id_p        (id_a_p),
    .data_bits_p (bits_a_p),
    .reset_val_p (reset_a_p)
  ) u_node_a (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .frame_i      (frame),
    .frame_done_i (frame_done),
    .data_o       (data_a_o)
  );

  cfg_node #(
    .id_p        (id_b_p),
    .data_bits_p (bits_b_p),
    .reset_val_p (reset_b_p)
  ) u_node_b (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .frame_i      (frame),
    .frame_done_i (frame_done),
    .data_o       (data_b_o)
  );

  cfg_node #(
    .id_p        (id_c_p),
    .data_bits_p (bits_c_p),
    .reset_val_p (reset_c_p)
  ) u_node_c (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .frame_i      (frame),
    .frame_done_i (frame_done),
    .data_o       (data_c_o)
  );

  assign frame_done_o = frame_done;

endmodule

// File: bench/cfg_node_properties.sv
module cfg_node_properties #(
  parameter int                     id_p        = 0,
  parameter int                     data_bits_p = 8,
  parameter logic [data_bits_p-1:0] reset_val_p = '0
) (
  input logic                   clk,
  input logic                   rst_n_i,
  input cfg_pkg::cfg_frame_s    frame_i,
  input logic                   frame_done_i,
  input logic [data_bits_p-1:0] data_o
);

  import cfg_pkg::*;

  logic                   match;
  logic [data_bits_p-1:0] low_payload;

  assign match       = frame_done_i && (frame_i.id == ID_BITS'(id_p));
  assign low_payload = frame_i.payload[data_bits_p-1:0];  // what a narrow node keeps

  // a reset cycle always leaves the reset value behind
  a_reset_value: assert property (
    @(posedge clk) !rst_n_i |=> (data_o == reset_val_p)
  ) else $error("node %0d: data %h after reset, expected %h", id_p, data_o, reset_val_p);

  // without a done strobe for this address the register holds
  a_hold_value: assert property (
    @(posedge clk) disable iff (!rst_n_i) !match |=> $stable(data_o)
  ) else $error("node %0d: data changed to %h without a matching frame", id_p, data_o);

  a_load_value: assert property (
    @(posedge clk) disable iff (!rst_n_i) match |=> (data_o == $past(low_payload))
  ) else $error("node %0d: data %h after a matching frame, expected %h",
                id_p, data_o, $past(low_payload));

endmodule

// every node instance gets its own checker
bind cfg_node cfg_node_properties #(
  .id_p        (id_p),
  .data_bits_p (data_bits_p),
  .reset_val_p (reset_val_p)
) u_node_props (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .frame_i      (frame_i),
  .frame_done_i (frame_done_i),
  .data_o       (data_o)
);

// File: bench/tb_cfg_network.sv
module tb_cfg_network;

  import cfg_pkg::*;

  localparam int          ID_A       = 3;
  localparam int          BITS_A     = 8;
  localparam logic [7:0]  RESET_A    = 8'h5a;
  localparam int          ID_B       = 17;
  localparam int          BITS_B     = 16;
  localparam logic [15:0] RESET_B    = 16'h1234;
  localparam int          ID_C       = 200;
  localparam int          BITS_C     = 4;
  localparam logic [3:0]  RESET_C    = 4'h9;
  localparam logic [7:0]  ID_NONE    = 8'h5e;  // no node answers here
  localparam int          WAIT_LIMIT = 200;    // cycles per frame end

  logic              clk;
  logic              rst_n_i;
  config_s           cfg_i;
  logic [BITS_A-1:0] data_a;
  logic [BITS_B-1:0] data_b;
  logic [BITS_C-1:0] data_c;
  logic              frame_done;
  logic              frame_err;

  // reference model state
  logic [BITS_A-1:0] exp_a;
  logic [BITS_B-1:0] exp_b;
  logic [BITS_C-1:0] exp_c;
  int                exp_done;
  int                exp_err;

  int          done_cnt;
  int          err_cnt;
  int          fail_count;
  int          check_count;
  int          test_count;
  logic [31:0] rng_state;

  cfg_network #(
    .id_a_p    (ID_A),
    .bits_a_p  (BITS_A),
    .reset_a_p (RESET_A),
    .id_b_p    (ID_B),
    .bits_b_p  (BITS_B),
    .reset_b_p (RESET_B),
    .id_c_p    (ID_C),
    .bits_c_p  (BITS_C),
    .reset_c_p (RESET_C)
  ) u_cfg_network (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .cfg_i        (cfg_i),
    .data_a_o     (data_a),
    .data_b_o     (data_b),
    .data_c_o     (data_c),
    .frame_done_o (frame_done),
    .frame_err_o  (frame_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // counted on the edge that closes each strobe, the nodes load on that same edge
  always @(posedge clk) begin
    if (!rst_n_i) begin
      done_cnt <= 0;
      err_cnt  <= 0;
    end else begin
      if (frame_done) done_cnt <= done_cnt + 1;
      if (frame_err) err_cnt <= err_cnt + 1;
    end
  end

  // xorshift32
  function logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic drive_bit(input logic b);
    cfg_i.valid = 1'b1;
    cfg_i.value = b;
    @(negedge clk);
  endtask

  task automatic drive_gap(input int len);
    logic [31:0] r;
    for (int i = 0; i < len; i++) begin
      r = next_random();
      cfg_i.valid = 1'b0;
      cfg_i.value = r[4];  // junk, must be ignored
      @(negedge clk);
    end
  endtask

  // start, id msb first, payload msb first, stop
  task automatic send_frame(input logic [ID_BITS-1:0] id,
                            input logic [PAYLOAD_BITS-1:0] payload,
                            input logic stop_bit, input bit gaps);
    logic [FRAME_BITS+1:0] bits;
    logic [31:0]           r;
    bits = {1'b1, id, payload, stop_bit};
    for (int i = FRAME_BITS + 1; i >= 0; i--) begin
      if (gaps) begin
        r = next_random();
        drive_gap(int'(r[1:0]));
      end
      drive_bit(bits[i]);
    end
  endtask

  task automatic model_frame(input logic [ID_BITS-1:0] id,
                             input logic [PAYLOAD_BITS-1:0] payload);
    exp_done++;
    if (id == ID_BITS'(ID_A)) exp_a = payload[BITS_A-1:0];
    if (id == ID_BITS'(ID_B)) exp_b = payload[BITS_B-1:0];
    if (id == ID_BITS'(ID_C)) exp_c = payload[BITS_C-1:0];
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    assert (actual === expected)
      else begin
        $display("[FAIL] %s: %s expected %0h, actual %0h", name, what, expected, actual);
        fail_count++;
      end
  endtask

  task automatic check_outputs(input string name);
    check_value(name, "data_a_o", 32'(exp_a), 32'(data_a));
    check_value(name, "data_b_o", 32'(exp_b), 32'(data_b));
    check_value(name, "data_c_o", 32'(exp_c), 32'(data_c));
    check_value(name, "frame_done_o count", 32'(exp_done), 32'(done_cnt));
    check_value(name, "frame_err_o count", 32'(exp_err), 32'(err_cnt));
  endtask

  task automatic wait_frame_end(input string name);
    int cycles;
    cycles = 0;
    cfg_i = '0;
    while ((done_cnt < exp_done || err_cnt < exp_err) && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (done_cnt < exp_done || err_cnt < exp_err) begin
      $display("%s: frame end strobe did not arrive within %0d cycles", name, WAIT_LIMIT);
      fail_count++;
    end
  endtask

  task automatic finish_test(input string name, input int fails_before);
    test_count++;
    if (fail_count == fails_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d failed checks", name, fail_count - fails_before);
    end
  endtask

  task automatic send_and_check(input string name, input logic [ID_BITS-1:0] id,
                                input logic [PAYLOAD_BITS-1:0] payload, input bit gaps);
    send_frame(id, payload, 1'b0, gaps);
    model_frame(id, payload);
    wait_frame_end(name);
    check_outputs(name);
  endtask

  task automatic test_reset_values();
    int f0;
    f0 = fail_count;
    check_outputs("reset_values");
    check_value("reset_values", "frame_done_o", 32'h0, 32'(frame_done));
    check_value("reset_values", "frame_err_o", 32'h0, 32'(frame_err));
    finish_test("reset_values", f0);
  endtask

  task automatic test_each_node();
    int f0;
    f0 = fail_count;
    send_and_check("each_node", ID_BITS'(ID_A), 16'hbeef, 1'b0);  // keeps ef
    send_and_check("each_node", ID_BITS'(ID_B), 16'hc0de, 1'b0);
    send_and_check("each_node", ID_BITS'(ID_C), 16'h7ff3, 1'b0);  // keeps 3
    finish_test("each_node", f0);
  endtask

  task automatic test_unknown_id();
    int f0;
    f0 = fail_count;
    send_and_check("unknown_id", ID_NONE, 16'hffff, 1'b0);
    send_and_check("unknown_id", 8'h00, 16'h0000, 1'b0);
    finish_test("unknown_id", f0);
  endtask

  task automatic test_bad_stop();
    int f0;
    f0 = fail_count;
    send_frame(ID_BITS'(ID_B), 16'h5555, 1'b1, 1'b0);
    exp_err++;  // error strobe only, no node moves
    wait_frame_end("bad_stop");
    check_outputs("bad_stop");
    send_and_check("bad_stop", ID_BITS'(ID_B), 16'haaaa, 1'b0);
    finish_test("bad_stop", f0);
  endtask

  task automatic test_random_gaps();
    int                      f0;
    logic [31:0]             r;
    logic [ID_BITS-1:0]      id;
    logic [PAYLOAD_BITS-1:0] payload;
    f0 = fail_count;
    for (int i = 0; i < 12; i++) begin
      r = next_random();
      case (r[1:0])
        2'd0:    id = ID_BITS'(ID_A);
        2'd1:    id = ID_BITS'(ID_B);
        2'd2:    id = ID_BITS'(ID_C);
        default: id = ID_NONE;
      endcase
      payload = r[23:8];
      send_and_check("random_gaps", id, payload, 1'b1);
      send_and_check("random_gaps", id, ~payload, 1'b0);  // same node, no gaps
    end
    finish_test("random_gaps", f0);
  endtask

  task automatic test_back_to_back();
    int f0;
    f0 = fail_count;
    send_frame(ID_BITS'(ID_A), 16'h0011, 1'b0, 1'b0);
    send_frame(ID_BITS'(ID_B), 16'h2233, 1'b0, 1'b0);  // start right after stop
    model_frame(ID_BITS'(ID_A), 16'h0011);
    model_frame(ID_BITS'(ID_B), 16'h2233);
    wait_frame_end("back_to_back");
    check_outputs("back_to_back");
    send_frame(ID_BITS'(ID_C), 16'h0004, 1'b0, 1'b0);
    send_frame(ID_BITS'(ID_C), 16'h000b, 1'b0, 1'b0);
    model_frame(ID_BITS'(ID_C), 16'h0004);
    model_frame(ID_BITS'(ID_C), 16'h000b);  // later frame wins
    wait_frame_end("back_to_back");
    check_outputs("back_to_back");
    finish_test("back_to_back", f0);
  endtask

  initial begin
    rng_state   = 32'hfb0e;
    cfg_i       = '0;
    rst_n_i     = 1'b0;
    exp_a       = RESET_A;
    exp_b       = RESET_B;
    exp_c       = RESET_C;
    exp_done    = 0;
    exp_err     = 0;
    fail_count  = 0;
    check_count = 0;
    test_count  = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    test_reset_values();
    test_each_node();
    test_unknown_id();
    test_bad_stop();
    test_random_gaps();
    test_back_to_back();

    $display("tests %0d, checks %0d, failures %0d", test_count, check_count, fail_count);
    if (fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: files.f
hw/cfg_pkg.sv
hw/cfg_bit_counter.sv
hw/cfg_shift_reg.sv
hw/cfg_frame_fsm.sv
hw/cfg_node.sv
hw/cfg_network.sv
bench/cfg_node_properties.sv
bench/tb_cfg_network.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_cfg_network
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := ERRORS FOUND
PASS_MSG  := NO ERRORS

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
